/* lisp_pkg.sv */
`default_nettype none

package lisp_pkg;

	localparam int WORD_W = 20;
	localparam int ADDR_W = 16;
	localparam int TAG_W = 4;
	localparam int IP_W = 18;
	localparam int MEM_SIZE = 8192;
	localparam int OP_W = 5;

	// Opcodes with both top bits set carry an immediate
	typedef enum logic [OP_W-1:0] {
		OP_NOP = 5'd0,
		OP_POP = 5'd3,
		OP_LOAD = 5'd4,
		OP_STORE = 5'd5,
		OP_ADD = 5'd6,
		OP_SUB = 5'd7,
		OP_GTR = 5'd9,
		OP_GTE = 5'd10,
		OP_EQ = 5'd11,
		OP_NEQ = 5'd12,
		OP_DUP = 5'd13,
		OP_GETTAG = 5'd14,
		OP_SETTAG = 5'd15,
		OP_AND = 5'd16,
		OP_OR = 5'd17,
		OP_XOR = 5'd18,
		OP_LSHIFT = 5'd19,
		OP_RSHIFT = 5'd20,
		OP_PUSH = 5'd25,
		OP_GOTO = 5'd26,
		OP_BFALSE = 5'd27
	} opcode_e;

	typedef enum logic [2:0] {
		STATE_IADDR_ISSUE = 3'd0,
		STATE_DECODE = 3'd1,
		STATE_GOT_NOS = 3'd2,
		STATE_LOAD_TOS1 = 3'd3,
		STATE_PUSH_MEM_RESULT = 3'd4
	} state_e;

	typedef enum logic [1:0] {SP_CURRENT, SP_DECREMENT, SP_INCREMENT} sp_sel_e;

	typedef enum logic [2:0] {
		TOS_CURRENT,
		TOS_TAG,
		TOS_PARAM,
		TOS_SETTAG,
		TOS_ALU,
		TOS_MEMORY
	} tos_sel_e;

	typedef enum logic [1:0] {MA_IP_NEXT, MA_SP, MA_TOS, MA_SP_MINUS_ONE} ma_sel_e;

	typedef enum logic {MW_TOS, MW_MEM_READ} mw_sel_e;

	typedef enum logic [1:0] {IP_CURRENT, IP_NEXT, IP_BRANCH} ip_sel_e;

	// One memory word, seen as tagged data or as four opcode slots
	typedef union packed {
		struct packed {
			logic [TAG_W-1:0] tag;
			logic [ADDR_W-1:0] value;
		} data;
		// Slot 0 sits in the top bits
		logic [0:3][OP_W-1:0] slots;
	} mem_word_u;

endpackage

`default_nettype wire

/* core_ctrl_if.sv */
`default_nettype none

interface core_ctrl_if;
	import lisp_pkg::*;

	sp_sel_e sp_sel;
	tos_sel_e tos_sel;
	ma_sel_e ma_sel;
	mw_sel_e mw_sel;
	ip_sel_e ip_sel;
	opcode_e alu_op;
	logic write_en;
	state_e state;

	modport sequencer (
		output sp_sel,
		output tos_sel,
		output ma_sel,
		output mw_sel,
		output ip_sel,
		output alu_op,
		output write_en,
		output state
	);

	modport datapath (
		input sp_sel,
		input tos_sel,
		input ma_sel,
		input mw_sel,
		input ip_sel,
		input alu_op,
		input write_en,
		input state
	);

endinterface

`default_nettype wire

/* slot_decode.sv */
`default_nettype none

module slot_decode (
	input logic clk,
	input logic rst_n,
	input lisp_pkg::state_e state,
	input lisp_pkg::mem_word_u mem_read_value,
	input logic [1:0] slot,
	output lisp_pkg::opcode_e opcode,
	output logic [lisp_pkg::WORD_W-1:0] param
);
	import lisp_pkg::*;

	mem_word_u latched_word;
	mem_word_u cur_word;

	// Cleared to an all-NOP word so the first fetch advances by one slot
	always_ff @(posedge clk)
	begin
		if (!rst_n)
			latched_word <= '0;
		else if (state == STATE_DECODE)
			latched_word <= mem_read_value;
	end

	// The fetched word is only on the bus during DECODE
	always_comb
	begin
		if (state == STATE_DECODE)
			cur_word = mem_read_value;
		else
			cur_word = latched_word;
	end

	always_comb
	begin
		opcode = opcode_e'(cur_word.slots[slot]);
		case (slot)
			2'd0:
				param = {{5{cur_word.slots[1][OP_W-1]}}, cur_word.slots[1],
					cur_word.slots[2], cur_word.slots[3]};
			2'd1:
				param = {{10{cur_word.slots[2][OP_W-1]}}, cur_word.slots[2],
					cur_word.slots[3]};
			2'd2:
				param = {{15{cur_word.slots[3][OP_W-1]}}, cur_word.slots[3]};
			default:
				param = '0;
		endcase
	end

	state_legal: assert property (@(posedge clk) disable iff (!rst_n)
		state inside {STATE_IADDR_ISSUE, STATE_DECODE, STATE_GOT_NOS,
			STATE_LOAD_TOS1, STATE_PUSH_MEM_RESULT});

endmodule

`default_nettype wire

/* op_sequencer.sv */
`default_nettype none

module op_sequencer (
	input logic clk,
	input logic rst_n,
	input lisp_pkg::opcode_e opcode,
	input logic tos_zero,
	core_ctrl_if.sequencer ctrl
);
	import lisp_pkg::*;

	state_e state_q;
	state_e state_next;

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			state_q <= STATE_IADDR_ISSUE;
		else
			state_q <= state_next;
	end

	assign ctrl.state = state_q;

	always_comb
	begin
		state_next = state_q;
		ctrl.sp_sel = SP_CURRENT;
		ctrl.tos_sel = TOS_CURRENT;
		ctrl.ma_sel = MA_IP_NEXT;
		ctrl.mw_sel = MW_TOS;
		ctrl.ip_sel = IP_CURRENT;
		ctrl.alu_op = opcode;
		ctrl.write_en = 1'b0;

		case (state_q)
			STATE_IADDR_ISSUE:
			begin
				ctrl.ip_sel = IP_NEXT;
				state_next = STATE_DECODE;
			end

			STATE_DECODE:
			begin
				case (opcode)
					OP_POP:
					begin
						ctrl.ma_sel = MA_SP;
						ctrl.sp_sel = SP_INCREMENT;
						state_next = STATE_PUSH_MEM_RESULT;
					end

					OP_LOAD:
					begin
						// Replace the top of stack with the word it points at
						ctrl.ma_sel = MA_TOS;
						state_next = STATE_PUSH_MEM_RESULT;
					end

					OP_GETTAG:
					begin
						ctrl.tos_sel = TOS_TAG;
						ctrl.ip_sel = IP_NEXT;
						state_next = STATE_DECODE;
					end

					OP_STORE, OP_ADD, OP_SUB, OP_GTR, OP_GTE, OP_EQ, OP_NEQ,
					OP_SETTAG, OP_AND, OP_OR, OP_XOR, OP_LSHIFT, OP_RSHIFT:
					begin
						// Fetch the next-on-stack first
						ctrl.ma_sel = MA_SP;
						state_next = STATE_GOT_NOS;
					end

					OP_DUP, OP_PUSH:
					begin
						// Spill the old top of stack below the stack pointer
						ctrl.sp_sel = SP_DECREMENT;
						ctrl.ma_sel = MA_SP_MINUS_ONE;
						ctrl.mw_sel = MW_TOS;
						ctrl.write_en = 1'b1;
						if (opcode == OP_PUSH)
							ctrl.tos_sel = TOS_PARAM;
						state_next = STATE_IADDR_ISSUE;
					end

					OP_GOTO:
					begin
						ctrl.ip_sel = IP_BRANCH;
						state_next = STATE_DECODE;
					end

					OP_BFALSE:
					begin
						ctrl.ip_sel = tos_zero ? IP_BRANCH : IP_NEXT;
						ctrl.ma_sel = MA_SP;
						ctrl.sp_sel = SP_INCREMENT;
						state_next = STATE_PUSH_MEM_RESULT;
					end

					default:
					begin
						ctrl.ip_sel = IP_NEXT;
						state_next = STATE_DECODE;
					end
				endcase
			end

			// Next-on-stack is on the read bus here
			STATE_GOT_NOS:
			begin
				ctrl.sp_sel = SP_INCREMENT;
				if (opcode == OP_STORE)
				begin
					ctrl.ma_sel = MA_TOS;
					ctrl.mw_sel = MW_MEM_READ;
					ctrl.write_en = 1'b1;
					state_next = STATE_LOAD_TOS1;
				end
				else
				begin
					ctrl.tos_sel = (opcode == OP_SETTAG) ? TOS_SETTAG : TOS_ALU;
					ctrl.ip_sel = IP_NEXT;
					state_next = STATE_DECODE;
				end
			end

			STATE_LOAD_TOS1:
			begin
				ctrl.ma_sel = MA_SP;
				ctrl.sp_sel = SP_INCREMENT;
				state_next = STATE_PUSH_MEM_RESULT;
			end

			STATE_PUSH_MEM_RESULT:
			begin
				ctrl.tos_sel = TOS_MEMORY;
				// A taken or untaken bfalse already moved the pointer
				if (opcode != OP_BFALSE)
					ctrl.ip_sel = IP_NEXT;
				state_next = STATE_DECODE;
			end

			default:
				state_next = STATE_IADDR_ISSUE;
		endcase
	end

	no_write_in_fetch: assert property (@(posedge clk) disable iff (!rst_n)
		(state_q == STATE_IADDR_ISSUE) |-> !ctrl.write_en);

	decode_write_to_stack: assert property (@(posedge clk) disable iff (!rst_n)
		(state_q == STATE_DECODE && ctrl.write_en)
			|-> ctrl.ma_sel inside {MA_SP, MA_SP_MINUS_ONE});

endmodule

`default_nettype wire

/* stack_alu.sv */
`default_nettype none

module stack_alu (
	input lisp_pkg::opcode_e alu_op,
	input logic [lisp_pkg::ADDR_W-1:0] tos,
	input logic [lisp_pkg::ADDR_W-1:0] nos,
	output logic [lisp_pkg::ADDR_W-1:0] alu_result
);
	import lisp_pkg::*;

	logic [ADDR_W-1:0] diff;
	logic zero;
	logic negative;

	// Compares all fall out of one subtractor
	assign diff = tos - nos;
	assign zero = (diff == '0);
	assign negative = diff[ADDR_W-1];

	always_comb
	begin
		case (alu_op)
			OP_ADD: alu_result = tos + nos;
			OP_SUB: alu_result = diff;
			OP_GTR: alu_result = ADDR_W'(!negative && !zero);
			OP_GTE: alu_result = ADDR_W'(!negative);
			OP_EQ: alu_result = ADDR_W'(zero);
			OP_NEQ: alu_result = ADDR_W'(!zero);
			OP_AND: alu_result = tos & nos;
			OP_OR: alu_result = tos | nos;
			OP_XOR: alu_result = tos ^ nos;
			OP_LSHIFT: alu_result = tos << nos;
			OP_RSHIFT: alu_result = tos >> nos;
			default: alu_result = '0;
		endcase
	end

endmodule

`default_nettype wire

/* stack_datapath.sv */
`default_nettype none

module stack_datapath (
	input logic clk,
	input logic rst_n,
	core_ctrl_if.datapath ctrl,
	input lisp_pkg::opcode_e opcode,
	input logic [lisp_pkg::WORD_W-1:0] param,
	input logic [lisp_pkg::ADDR_W-1:0] alu_result,
	input lisp_pkg::mem_word_u mem_read_value,
	output logic [1:0] slot,
	output logic [lisp_pkg::ADDR_W-1:0] tos,
	output logic tos_zero,
	output logic [lisp_pkg::ADDR_W-1:0] memory_address,
	output logic [lisp_pkg::WORD_W-1:0] mem_write_value,
	output logic mem_write_enable
);
	import lisp_pkg::*;

	mem_word_u tos_q;
	mem_word_u tos_next;
	logic [ADDR_W-1:0] sp_q;
	logic [ADDR_W-1:0] sp_next;
	logic [ADDR_W-1:0] sp_minus_one;
	logic [IP_W-1:0] ip_q;
	logic [IP_W-1:0] ip_next;
	logic [IP_W-1:0] ip_word_base;
	logic has_imm;

	assign sp_minus_one = sp_q - ADDR_W'(1);
	assign ip_word_base = {ip_q[IP_W-1:2], 2'b00};
	assign has_imm = (opcode[OP_W-1 -: 2] == 2'b11);

	always_comb
	begin
		case (ctrl.sp_sel)
			SP_DECREMENT: sp_next = sp_minus_one;
			SP_INCREMENT: sp_next = sp_q + ADDR_W'(1);
			default: sp_next = sp_q;
		endcase
	end

	always_comb
	begin
		tos_next = tos_q;
		case (ctrl.tos_sel)
			TOS_TAG:
			begin
				tos_next.data.tag = '0;
				tos_next.data.value = ADDR_W'(tos_q.data.tag);
			end
			TOS_PARAM: tos_next = param;
			// New tag comes from the low bits of next-on-stack
			TOS_SETTAG: tos_next.data.tag = mem_read_value.data.value[TAG_W-1:0];
			TOS_ALU: tos_next.data.value = alu_result;
			TOS_MEMORY: tos_next = mem_read_value;
			default: tos_next = tos_q;
		endcase
	end

	always_comb
	begin
		case (ctrl.ip_sel)
			IP_NEXT:
			begin
				// An immediate fills the rest of the word
				if (has_imm)
					ip_next = ip_word_base + IP_W'(4);
				else
					ip_next = ip_q + IP_W'(1);
			end
			IP_BRANCH: ip_next = ip_word_base + {param[IP_W-3:0], 2'b00};
			default: ip_next = ip_q;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			tos_q <= '0;
			sp_q <= ADDR_W'(MEM_SIZE - 8);
			// Wraps to word 0 slot 0 on the first fetch
			ip_q <= '1;
		end
		else
		begin
			tos_q <= tos_next;
			sp_q <= sp_next;
			ip_q <= ip_next;
		end
	end

	always_comb
	begin
		case (ctrl.ma_sel)
			MA_SP: memory_address = sp_q;
			MA_TOS: memory_address = tos_q.data.value;
			MA_SP_MINUS_ONE: memory_address = sp_minus_one;
			default: memory_address = ip_next[IP_W-1:2];
		endcase
	end

	assign mem_write_value = (ctrl.mw_sel == MW_MEM_READ) ? mem_read_value : tos_q;
	assign mem_write_enable = ctrl.write_en;

	assign slot = ip_q[1:0];
	assign tos = tos_q.data.value;
	assign tos_zero = (tos_q.data.value == '0);

endmodule

`default_nettype wire

/* lisp_core.sv */
`default_nettype none

module lisp_core (
	input logic clk,
	input logic rst_n,
	output logic [lisp_pkg::ADDR_W-1:0] memory_address,
	input logic [lisp_pkg::WORD_W-1:0] mem_read_value,
	output logic [lisp_pkg::WORD_W-1:0] mem_write_value,
	output logic mem_write_enable
);
	import lisp_pkg::*;

	opcode_e opcode;
	logic [WORD_W-1:0] param;
	logic [1:0] slot;
	logic [ADDR_W-1:0] tos;
	logic tos_zero;
	logic [ADDR_W-1:0] alu_result;

	core_ctrl_if ctrl ();

	slot_decode slot_decode_inst (
		.clk(clk),
		.rst_n(rst_n),
		.state(ctrl.state),
		.mem_read_value(mem_read_value),
		.slot(slot),
		.opcode(opcode),
		.param(param)
	);

	op_sequencer op_sequencer_inst (
		.clk(clk),
		.rst_n(rst_n),
		.opcode(opcode),
		.tos_zero(tos_zero),
		.ctrl(ctrl.sequencer)
	);

	// Next-on-stack arrives straight off the read bus
	stack_alu stack_alu_inst (
		.alu_op(ctrl.alu_op),
		.tos(tos),
		.nos(mem_read_value[ADDR_W-1:0]),
		.alu_result(alu_result)
	);

	stack_datapath stack_datapath_inst (
		.clk(clk),
		.rst_n(rst_n),
		.ctrl(ctrl.datapath),
		.opcode(opcode),
		.param(param),
		.alu_result(alu_result),
		.mem_read_value(mem_read_value),
		.slot(slot),
		.tos(tos),
		.tos_zero(tos_zero),
		.memory_address(memory_address),
		.mem_write_value(mem_write_value),
		.mem_write_enable(mem_write_enable)
	);

endmodule

`default_nettype wire

/* tb_programs.svh */
`ifndef TB_PROGRAMS_SVH
`define TB_PROGRAMS_SVH

// Each entry holds the program words at address 0, one preset word at DATA_ADDR,
// and the address and word that its first store below 16'h1000 must show
localparam int NUM_ENTRIES = 28;
localparam int PROG_LEN = 10;
localparam logic [15:0] RESULT_BASE = 16'h0800;
localparam logic [15:0] DATA_ADDR = 16'h0400;
localparam logic [15:0] BAD_MARK = 16'h3bad;

mem_word_u prog_words [NUM_ENTRIES][PROG_LEN];
mem_word_u preset_word [NUM_ENTRIES];
mem_word_u exp_word [NUM_ENTRIES];
logic [15:0] exp_addr [NUM_ENTRIES];
string entry_name [NUM_ENTRIES];
int cur_entry;
int cur_pos;

function automatic logic [15:0] result_addr(int entry);
	return RESULT_BASE + 16'(entry);
endfunction

task automatic start_entry();
	int p;
	// Unused words hold a self loop
	for (p = 0; p < PROG_LEN; p++)
		prog_words[cur_entry][p] = imm_word(OP_GOTO, 15'd0);
	preset_word[cur_entry] = data_word(4'h0, 16'h0000);
	cur_pos = 0;
endtask

task automatic emit(mem_word_u w);
	prog_words[cur_entry][cur_pos] = w;
	cur_pos++;
endtask

// Push the result address, store, then loop forever
task automatic end_entry(string name, mem_word_u expected);
	logic [15:0] addr;
	addr = result_addr(cur_entry);
	emit(imm_word(OP_PUSH, addr[14:0]));
	emit(slot_word(OP_STORE, OP_NOP, OP_NOP, OP_NOP));
	emit(imm_word(OP_GOTO, 15'd0));
	exp_addr[cur_entry] = addr;
	exp_word[cur_entry] = expected;
	entry_name[cur_entry] = name;
	cur_entry++;
endtask

task automatic build_table();
	opcode_e arith_ops [7];
	opcode_e cmp_ops [4];
	logic [15:0] a;
	logic [15:0] b;
	logic [15:0] x;
	logic [15:0] y;
	logic [15:0] tos_v;
	logic [15:0] nos_v;
	logic [15:0] addr;
	int i;
	int k;
	arith_ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_LSHIFT, OP_RSHIFT};
	cmp_ops = '{OP_GTR, OP_GTE, OP_EQ, OP_NEQ};
	cur_entry = 0;
	seed = 32'h2c236e45;

	draw(a, 16'h3fff);
	start_entry();
	emit(imm_word(OP_PUSH, a[14:0]));
	end_entry("basic store", data_word(4'h0, a));

	// Next-on-stack is pushed first, and is the shift count for the shifts
	for (i = 0; i < 7; i++)
	begin
		draw(a, (arith_ops[i] inside {OP_LSHIFT, OP_RSHIFT}) ? 16'h000f : 16'h3fff);
		draw(b, 16'h3fff);
		start_entry();
		emit(imm_word(OP_PUSH, a[14:0]));
		emit(imm_word(OP_PUSH, b[14:0]));
		emit(slot_word(arith_ops[i], OP_NOP, OP_NOP, OP_NOP));
		end_entry(arith_ops[i].name(), data_word(4'h0, alu_model(arith_ops[i], b, a)));
	end

	// Equal, greater and smaller pairs for every compare
	for (i = 0; i < 4; i++)
	begin
		for (k = 0; k < 3; k++)
		begin
			draw(x, 16'h3fff);
			draw(y, 16'h3fff);
			if (x == y)
				y = x ^ 16'h0001;
			if (k == 0)
			begin
				tos_v = x;
				nos_v = x;
			end
			else
			begin
				tos_v = ((x > y) == (k == 1)) ? x : y;
				nos_v = ((x > y) == (k == 1)) ? y : x;
			end
			start_entry();
			emit(imm_word(OP_PUSH, nos_v[14:0]));
			emit(imm_word(OP_PUSH, tos_v[14:0]));
			emit(slot_word(cmp_ops[i], OP_NOP, OP_NOP, OP_NOP));
			end_entry($sformatf("%s case %0d", cmp_ops[i].name(), k),
				data_word(4'h0, alu_model(cmp_ops[i], tos_v, nos_v)));
		end
	end

	// Taken bfalse jumps over the store of the wrong marker
	draw(a, 16'h0fff);
	start_entry();
	addr = result_addr(cur_entry);
	emit(imm_word(OP_PUSH, 15'd0));
	emit(imm_word(OP_BFALSE, 15'd4));
	emit(imm_word(OP_PUSH, BAD_MARK[14:0]));
	emit(imm_word(OP_PUSH, addr[14:0]));
	emit(slot_word(OP_STORE, OP_NOP, OP_NOP, OP_NOP));
	emit(imm_word(OP_PUSH, a[14:0]));
	end_entry("bfalse taken", data_word(4'h0, a));

	draw(a, 16'h0fff);
	draw(b, 16'h0fff);
	start_entry();
	addr = result_addr(cur_entry);
	emit(imm_word(OP_PUSH, b[14:0] | 15'd1));
	emit(imm_word(OP_BFALSE, 15'd4));
	emit(imm_word(OP_PUSH, a[14:0]));
	emit(imm_word(OP_PUSH, addr[14:0]));
	emit(slot_word(OP_STORE, OP_NOP, OP_NOP, OP_NOP));
	emit(imm_word(OP_PUSH, BAD_MARK[14:0]));
	end_entry("bfalse not taken", data_word(4'h0, a));

	draw(a, 16'h0fff);
	start_entry();
	emit(imm_word(OP_PUSH, a[14:0]));
	emit(imm_word(OP_GOTO, 15'd2));
	emit(imm_word(OP_PUSH, BAD_MARK[14:0]));
	end_entry("goto skip", data_word(4'h0, a));

	draw(a, 16'h3fff);
	start_entry();
	emit(imm_word(OP_PUSH, a[14:0]));
	emit(slot_word(OP_DUP, OP_ADD, OP_NOP, OP_NOP));
	end_entry("dup add", data_word(4'h0, a + a));

	draw(a, 16'h3fff);
	draw(b, 16'h3fff);
	start_entry();
	emit(imm_word(OP_PUSH, a[14:0]));
	emit(imm_word(OP_PUSH, b[14:0]));
	emit(slot_word(OP_POP, OP_NOP, OP_NOP, OP_NOP));
	end_entry("pop", data_word(4'h0, a));

	draw(a, 16'hffff);
	start_entry();
	preset_word[cur_entry] = data_word(4'h3, a);
	emit(imm_word(OP_PUSH, DATA_ADDR[14:0]));
	emit(slot_word(OP_LOAD, OP_NOP, OP_NOP, OP_NOP));
	end_entry("load", data_word(4'h3, a));

	// Tag is pushed first, the value second
	draw(a, 16'h000f);
	draw(b, 16'h3fff);
	start_entry();
	emit(imm_word(OP_PUSH, a[14:0] | 15'd1));
	emit(imm_word(OP_PUSH, b[14:0]));
	emit(slot_word(OP_SETTAG, OP_NOP, OP_NOP, OP_NOP));
	end_entry("settag", data_word(a[3:0] | 4'h1, b));

	draw(a, 16'h000f);
	draw(b, 16'h3fff);
	start_entry();
	emit(imm_word(OP_PUSH, a[14:0] | 15'd1));
	emit(imm_word(OP_PUSH, b[14:0]));
	emit(slot_word(OP_SETTAG, OP_GETTAG, OP_NOP, OP_NOP));
	end_entry("gettag", data_word(4'h0, {12'h000, a[3:0] | 4'h1}));
endtask

`endif

/* tb_lisp_core.sv */
`default_nettype none

module tb_lisp_core;
	import lisp_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 5;
	localparam int RESET_CYCLES = 16;
	localparam int MEM_AW = $clog2(MEM_SIZE);

	logic clk = 1'b0;
	logic rst_n;
	logic [ADDR_W-1:0] memory_address;
	logic [WORD_W-1:0] mem_read_value;
	logic [WORD_W-1:0] mem_write_value;
	logic mem_write_enable;

	logic [WORD_W-1:0] mem [MEM_SIZE];
	logic [ADDR_W-1:0] cap_addr;
	logic cap_we;
	logic [WORD_W-1:0] cap_data;

	logic [31:0] seed;
	int cycle_count = 0;
	logic found;

	function automatic logic [31:0] lcg_next(logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic draw(output logic [15:0] v, input logic [15:0] mask);
		seed = lcg_next(seed);
		v = seed[31:16] & mask;
	endtask

	function automatic mem_word_u imm_word(opcode_e op, logic [14:0] imm);
		mem_word_u w;
		w.slots[0] = op;
		{w.slots[1], w.slots[2], w.slots[3]} = imm;
		return w;
	endfunction

	function automatic mem_word_u slot_word(opcode_e a, opcode_e b, opcode_e c, opcode_e d);
		mem_word_u w;
		w.slots[0] = a;
		w.slots[1] = b;
		w.slots[2] = c;
		w.slots[3] = d;
		return w;
	endfunction

	function automatic mem_word_u data_word(logic [3:0] tag, logic [15:0] value);
		mem_word_u w;
		w.data.tag = tag;
		w.data.value = value;
		return w;
	endfunction

	// Expected result with the top of stack as the first operand
	function automatic logic [15:0] alu_model(opcode_e op, logic [15:0] tos, logic [15:0] nos);
		logic signed [15:0] diff;
		diff = $signed(tos - nos);
		case (op)
			OP_ADD: return tos + nos;
			OP_SUB: return tos - nos;
			OP_AND: return tos & nos;
			OP_OR: return tos | nos;
			OP_XOR: return tos ^ nos;
			OP_LSHIFT: return tos << nos;
			OP_RSHIFT: return tos >> nos;
			OP_GTR: return (diff > 0) ? 16'd1 : 16'd0;
			OP_GTE: return (diff >= 0) ? 16'd1 : 16'd0;
			OP_EQ: return (diff == 0) ? 16'd1 : 16'd0;
			OP_NEQ: return (diff != 0) ? 16'd1 : 16'd0;
			default: return 16'd0;
		endcase
	endfunction

	`include "tb_programs.svh"

	localparam int TIMEOUT_CYCLES = 400 * NUM_ENTRIES;

	always #(CLK_PERIOD / 2) clk = ~clk;

	lisp_core lisp_core_inst (
		.clk(clk),
		.rst_n(rst_n),
		.memory_address(memory_address),
		.mem_read_value(mem_read_value),
		.mem_write_value(mem_write_value),
		.mem_write_enable(mem_write_enable)
	);

	// Memory model samples mid cycle and answers just after the next edge
	always @(negedge clk)
	begin
		cap_addr = memory_address;
		cap_we = mem_write_enable;
		cap_data = mem_write_value;
	end

	always @(posedge clk)
	begin
		#DRIVE_DELAY;
		mem_read_value = mem[cap_addr[MEM_AW-1:0]];
		if (cap_we)
			mem[cap_addr[MEM_AW-1:0]] = cap_data;
	end

	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: no result store seen within %0d clock cycles", TIMEOUT_CYCLES);
			$display("TEST RESULT: FAIL");
			$fatal(1, "simulation stopped by the cycle limit");
		end
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected)
		begin
			$display("[ERROR] %0t: %s: got %0h, expected %0h", $time, what, got, expected);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch in %s", what);
		end
	endtask

	task automatic load_memory(int e);
		int a;
		int p;
		for (a = 0; a < MEM_SIZE; a++)
			mem[a] = WORD_W'(a) ^ 20'h5a5a5;
		for (p = 0; p < PROG_LEN; p++)
			mem[p] = prog_words[e][p];
		mem[DATA_ADDR[MEM_AW-1:0]] = preset_word[e];
	endtask

	task automatic run_entry(int e);
		int i;
		@(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b0;
		for (i = 0; i < RESET_CYCLES; i++)
		begin
			@(negedge clk);
			if (i > 0)
				check_value("write strobe in reset", 32'(mem_write_enable), 32'd0);
		end
		load_memory(e);
		@(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		@(negedge clk);
		check_value("first fetch address", 32'(memory_address), 32'd0);

		// The first store below 16'h1000 carries the result
		found = 1'b0;
		while (!found)
		begin
			@(negedge clk);
			if (mem_write_enable && memory_address < 16'h1000)
				found = 1'b1;
		end
		check_value({entry_name[e], " address"}, 32'(memory_address), 32'(exp_addr[e]));
		check_value({entry_name[e], " word"}, 32'(mem_write_value), 32'(exp_word[e]));
	endtask

	initial
	begin
		rst_n = 1'b0;
		mem_read_value = '0;
		cap_addr = '0;
		cap_we = 1'b0;
		cap_data = '0;
		build_table();
		for (int e = 0; e < NUM_ENTRIES; e++)
			run_entry(e);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
lisp_pkg.sv
core_ctrl_if.sv
slot_decode.sv
op_sequencer.sv
stack_alu.sv
stack_datapath.sv
lisp_core.sv
tb_lisp_core.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_lisp_core -f tb.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^TEST RESULT: PASS$" sim.log; then
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
